/* src/spi_hex_pkg.sv */
//////////////////////////////////////////////////
// Panel geometry, OLED bus structs, hex font
// and SSD1331 init command table
//////////////////////////////////////////////////
`default_nettype none

package spi_hex_pkg;

    localparam int oled_width   = 96;
    localparam int oled_height  = 64;
    localparam int glyph_width  = 6;  // 5 font columns plus spacing
    localparam int glyph_height = 8;  // 7 font rows plus spacing
    localparam int init_len     = 12;
    localparam int reset_cycles = 32;

    typedef struct packed {
        logic [6:0] x;
        logic [5:0] y;
    } pixel_pos_t;

    typedef struct packed {
        logic csn;
        logic sclk;
        logic mosi;
        logic dc;
        logic resn;
    } oled_pins_t;

    // 5x7 hex glyphs, row 0 in the top bits, leftmost pixel is MSB of a row
    function automatic logic [4:0] font_row(input logic [3:0] digit, input logic [2:0] row);
        logic [34:0] glyph;
        case (digit)
            4'h0: glyph = {5'h0E, 5'h11, 5'h13, 5'h15, 5'h19, 5'h11, 5'h0E};
            4'h1: glyph = {5'h04, 5'h0C, 5'h04, 5'h04, 5'h04, 5'h04, 5'h0E};
            4'h2: glyph = {5'h0E, 5'h11, 5'h01, 5'h02, 5'h04, 5'h08, 5'h1F};
            4'h3: glyph = {5'h1F, 5'h02, 5'h04, 5'h02, 5'h01, 5'h11, 5'h0E};
            4'h4: glyph = {5'h02, 5'h06, 5'h0A, 5'h12, 5'h1F, 5'h02, 5'h02};
            4'h5: glyph = {5'h1F, 5'h10, 5'h1E, 5'h01, 5'h01, 5'h11, 5'h0E};
            4'h6: glyph = {5'h06, 5'h08, 5'h10, 5'h1E, 5'h11, 5'h11, 5'h0E};
            4'h7: glyph = {5'h1F, 5'h01, 5'h02, 5'h04, 5'h08, 5'h08, 5'h08};
            4'h8: glyph = {5'h0E, 5'h11, 5'h11, 5'h0E, 5'h11, 5'h11, 5'h0E};
            4'h9: glyph = {5'h0E, 5'h11, 5'h11, 5'h0F, 5'h01, 5'h02, 5'h0C};
            4'hA: glyph = {5'h0E, 5'h11, 5'h11, 5'h11, 5'h1F, 5'h11, 5'h11};
            4'hB: glyph = {5'h1E, 5'h11, 5'h11, 5'h1E, 5'h11, 5'h11, 5'h1E};
            4'hC: glyph = {5'h0E, 5'h11, 5'h10, 5'h10, 5'h10, 5'h11, 5'h0E};
            4'hD: glyph = {5'h1C, 5'h12, 5'h11, 5'h11, 5'h11, 5'h12, 5'h1C};
            4'hE: glyph = {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h1F};
            default: glyph = {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h10};
        endcase
        if (row == 3'd7)
            return 5'b00000; // Spacing row
        return glyph[34 - 5 * int'(row) -: 5];
    endfunction

    function automatic logic [7:0] init_byte(input int unsigned idx);
        case (idx)
            0:  return 8'hAE; // Display off
            1:  return 8'hA0; // Remap and colour depth
            2:  return 8'h22; // 8 bit colour, COM split, column flip
            3:  return 8'hA1; // Start line
            4:  return 8'h00;
            5:  return 8'hA2; // Display offset
            6:  return 8'h00;
            7:  return 8'hAD; // Master configuration
            8:  return 8'h8E;
            9:  return 8'h87; // Master current, scales all three channels
            10: return 8'h0F;
            default: return 8'hAF; // Display on
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/spi_slave.sv */
//////////////////////////////////////////////////
// Serial shift register fed from button lines
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spi_slave #(
    parameter int data_len = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sclk,
    input  logic                mosi,
    output logic [data_len-1:0] data
);

    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;
    logic       sclk_rise;

    // Rising edge seen after two sync stages
    assign sclk_rise = sclk_sync[1] & ~sclk_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            sclk_prev <= 1'b0;
            data      <= '0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            sclk_prev <= sclk_sync[1];
            if (sclk_rise)
                data <= {data[data_len-2:0], mosi_sync[1]}; // Newest bit at LSB
        end
    end

endmodule

`default_nettype wire

/* src/hex_decoder.sv */
//////////////////////////////////////////////////
// Raster walker and glyph lookup for the
// two text lines of the display word
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hex_decoder
    import spi_hex_pkg::*;
#(
    parameter int         display_len = 128,
    parameter logic [7:0] fg_color    = 8'hFF,
    parameter logic [7:0] bg_color    = 8'h00
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [display_len-1:0] display,
    input  logic                   next_pixel,
    output pixel_pos_t             pos,
    output logic [7:0]             color
);

    localparam int chars_per_line = oled_width / glyph_width; // 16 digits
    localparam int line_bits      = chars_per_line * 4;
    localparam int text_lines     = display_len / line_bits;
    localparam int font_cols      = glyph_width - 1;
    localparam int col_w          = $clog2(chars_per_line);
    localparam int gx_w           = $clog2(glyph_width);

    logic [gx_w-1:0]  glyph_x;  // Column inside the character cell
    logic [col_w-1:0] char_col;
    logic [2:0]       glyph_y;
    int unsigned      line_idx;
    int unsigned      nib_base;
    logic [3:0]       digit;
    logic [4:0]       glyph_row;
    logic             pixel_on;

    // Raster position, x first then y
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos      <= '0;
            glyph_x  <= '0;
            char_col <= '0;
        end else if (next_pixel) begin
            if (pos.x == 7'(oled_width - 1)) begin
                pos.x    <= '0;
                glyph_x  <= '0;
                char_col <= '0;
                if (pos.y == 6'(oled_height - 1))
                    pos.y <= '0; // Wrap to next frame
                else
                    pos.y <= pos.y + 6'd1;
            end else begin
                pos.x <= pos.x + 7'd1;
                if (glyph_x == gx_w'(glyph_width - 1)) begin
                    glyph_x  <= '0;
                    char_col <= char_col + 1'b1;
                end else begin
                    glyph_x <= glyph_x + 1'b1;
                end
            end
        end
    end

    assign glyph_y  = 3'(pos.y % glyph_height);
    assign line_idx = pos.y / glyph_height;

    always_comb begin
        nib_base  = 0;
        digit     = 4'h0;
        glyph_row = 5'b00000;
        pixel_on  = 1'b0;
        if (line_idx < text_lines) begin
            // Leftmost column shows the top nibble of its line
            nib_base  = line_idx * line_bits + (chars_per_line - 1 - char_col) * 4;
            digit     = display[nib_base +: 4];
            glyph_row = font_row(digit, glyph_y);
            if (glyph_x < font_cols)
                pixel_on = glyph_row[font_cols - 1 - glyph_x];
        end
    end

    // Settles one cycle after pos moves
    always_ff @(posedge clk) begin
        color <= pixel_on ? fg_color : bg_color;
    end

endmodule

`default_nettype wire

/* src/oled_video.sv */
//////////////////////////////////////////////////
// OLED driver: panel reset, init commands,
// endless pixel byte stream over SPI mode 0
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module oled_video
    import spi_hex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] color,
    output logic       next_pixel,
    output oled_pins_t pins
);

    localparam int sclk_phases = 16;              // Two clk cycles per bit
    localparam int byte_slots  = sclk_phases + 2; // Plus csn high gap

    typedef enum logic [1:0] {
        RESET,
        INIT,
        PIXEL
    } state_t;

    state_t                          state;
    logic [$clog2(reset_cycles)-1:0] reset_cnt;
    logic [$clog2(init_len)-1:0]     init_idx;
    logic [4:0]                      slot_cnt;
    logic [7:0]                      shreg;
    logic [7:0]                      load_byte;
    logic                            load;
    logic                            shift;

    // A new byte starts when the previous slot including its gap is over
    assign load      = (state != RESET) && (slot_cnt == 5'(byte_slots - 1));
    assign load_byte = (state == INIT) ? init_byte(init_idx) : color;
    assign shift     = (state != RESET) && !load
                       && (slot_cnt < 5'(sclk_phases)) && pins.sclk;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= RESET;
            reset_cnt  <= '0;
            init_idx   <= '0;
            slot_cnt   <= 5'(byte_slots - 1);
            next_pixel <= 1'b0;
            pins       <= '{csn: 1'b1, sclk: 1'b0, mosi: 1'b0, dc: 1'b0, resn: 1'b0};
        end else begin
            next_pixel <= 1'b0;

            case (state)
                RESET: begin
                    if (reset_cnt == ($clog2(reset_cycles))'(reset_cycles - 1)) begin
                        pins.resn <= 1'b1; // Release panel reset
                        state     <= INIT;
                    end else begin
                        reset_cnt <= reset_cnt + 1'b1;
                    end
                end
                INIT: begin
                    if (load) begin
                        init_idx <= init_idx + 1'b1;
                        if (init_idx == ($clog2(init_len))'(init_len - 1))
                            state <= PIXEL;
                    end
                end
                PIXEL: begin
                    if (load)
                        next_pixel <= 1'b1; // Decoder steps to the next pixel
                end
                default: state <= RESET;
            endcase

            if (load) begin
                slot_cnt  <= '0;
                pins.csn  <= 1'b0;
                pins.sclk <= 1'b0;
                pins.mosi <= load_byte[7]; // MSB first
                pins.dc   <= (state == PIXEL);
            end else if (state != RESET) begin
                slot_cnt <= slot_cnt + 5'd1;
                if (slot_cnt < 5'(sclk_phases)) begin
                    pins.sclk <= ~pins.sclk;
                    if (shift)
                        pins.mosi <= shreg[6]; // Next bit on the falling edge
                    if (slot_cnt == 5'(sclk_phases - 1))
                        pins.csn <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            shreg <= load_byte;
        else if (shift)
            shreg <= {shreg[6:0], 1'b0};
    end

endmodule

`default_nettype wire

/* src/top_spi_hex.sv */
//////////////////////////////////////////////////
// Top level: serial input, display mapping,
// decoder and OLED driver
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module top_spi_hex
    import spi_hex_pkg::*;
#(
    parameter int         data_len    = 64,
    parameter int         display_len = 128,
    parameter logic [7:0] fg_color    = 8'hFF,
    parameter logic [7:0] bg_color    = 8'h00
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [6:0] btn,
    output logic [7:0] led,
    output logic       oled_csn,
    output logic       oled_clk,
    output logic       oled_mosi,
    output logic       oled_dc,
    output logic       oled_resn,
    input  logic       wifi_gpio5,
    output logic       wifi_gpio0
);

    localparam int digits = data_len / 4;

    logic [data_len-1:0]    data;
    logic [display_len-1:0] display;
    logic                   next_pixel;
    logic [7:0]             color;
    oled_pins_t             pins;

    assign wifi_gpio0 = btn[0];
    assign led        = {3'b000, wifi_gpio5, 4'b0000};

    // btn[1] carries data, btn[2] the serial clock
    spi_slave #(
        .data_len(data_len)
    ) spi_slave_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .sclk (btn[2]),
        .mosi (btn[1]),
        .data (data)
    );

    // Lower line is plain hex, newest nibble at the right
    assign display[display_len-1 -: data_len] = data;

    // Upper line is a bit trace, newest bit at the left
    for (genvar i = 0; i < digits; i++) begin : g_trace
        assign display[4*i +: 4] = {3'b000, data[digits-1-i]};
    end

    hex_decoder #(
        .display_len(display_len),
        .fg_color   (fg_color),
        .bg_color   (bg_color)
    ) hex_decoder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .display   (display),
        .next_pixel(next_pixel),
        .pos       (),
        .color     (color)
    );

    oled_video oled_video_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .color     (color),
        .next_pixel(next_pixel),
        .pins      (pins)
    );

    assign oled_csn  = pins.csn;
    assign oled_clk  = pins.sclk;
    assign oled_mosi = pins.mosi;
    assign oled_dc   = pins.dc;
    assign oled_resn = pins.resn;

endmodule

`default_nettype wire

/* verif/spi_hex_assert.sv */
//////////////////////////////////////////////////
// OLED bus protocol assertions, bound to oled_video
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spi_hex_assert
    import spi_hex_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       next_pixel,
    input oled_pins_t pins
);

    // Mode 0, data moves only with sclk low
    a_mosi_dc_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable({pins.mosi, pins.dc}) |-> !pins.sclk)
        else $error("mosi or dc changed while sclk was high");

    a_sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        pins.csn |-> !pins.sclk)
        else $error("sclk high while csn was high");

    a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        next_pixel |=> !next_pixel)
        else $error("next_pixel lasted two cycles");

endmodule

bind oled_video spi_hex_assert oled_bus_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .next_pixel(next_pixel),
    .pins      (pins)
);

`default_nettype wire

/* verif/tb_top_spi_hex.sv */
//////////////////////////////////////////////////
// Testbench for the SPI hex monitor with serial
// stimulus, OLED bus decoder, pixel model and checks
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_top_spi_hex
    import spi_hex_pkg::*;
();

    localparam logic [7:0] fg_color     = 8'hFF;
    localparam logic [7:0] bg_color     = 8'h00;
    localparam int         byte_cycles  = 18;
    localparam int         frame_pixels = oled_width * oled_height;
    localparam int         shift_cycles = 64 * 10;
    // Blank frame, four words at two frames each, one spare frame
    localparam int         run_frames   = 1 + 2 * 4 + 1;
    localparam longint     timeout_ns   = 10 * (longint'(run_frames) * frame_pixels * byte_cycles
                                          + reset_cycles + init_len * byte_cycles
                                          + 4 * shift_cycles + 100);

    logic       clk;
    logic       rst_n;
    logic [6:0] btn;
    logic [7:0] led;
    logic       oled_csn;
    logic       oled_clk;
    logic       oled_mosi;
    logic       oled_dc;
    logic       oled_resn;
    logic       wifi_gpio5;
    logic       wifi_gpio0;

    integer      seed;
    logic [63:0] model_word;      // Mirror of the DUT shift register
    logic [63:0] frame_word;      // Word in force for the frame under check
    logic [8:0]  bus_q[$];        // {dc, byte} as decoded from the pins
    logic [7:0]  rx_byte;
    int          rx_bits        = 0;
    logic        checking       = 1'b0;
    int          error_count    = 0;
    int          tests_passed   = 0;
    int          tests_failed   = 0;
    int          init_seen      = 0;
    int          pixel_seen     = 0;
    int          frame_end_cnt  = 0;
    int          frames_checked = 0;
    int          check_req_cnt  = 0;
    int          check_ack_cnt  = 0;

    top_spi_hex #(
        .data_len   (64),
        .display_len(128),
        .fg_color   (fg_color),
        .bg_color   (bg_color)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn       (btn),
        .led       (led),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn),
        .wifi_gpio5(wifi_gpio5),
        .wifi_gpio0(wifi_gpio0)
    );

    always #5 clk = ~clk;

    // Lower line is hex, upper line a binary trace with bit 0 leftmost
    function automatic logic [7:0] expected_color(input logic [63:0] word, input int x,
                                                  input int y);
        int         col;
        int         gx;
        int         gy;
        logic [3:0] digit;
        logic [4:0] pattern;
        col = x / glyph_width;
        gx  = x % glyph_width;
        gy  = y % glyph_height;
        if (y >= 2 * glyph_height || gx >= glyph_width - 1 || gy >= glyph_height - 1)
            return bg_color;
        if (y < glyph_height)
            digit = {3'b000, word[col]};
        else
            digit = word[63 - 4 * col -: 4];
        pattern = font_row(digit, 3'(gy));
        return pattern[4 - gx] ? fg_color : bg_color;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic shift_word(input logic [63:0] word);
        for (int i = 63; i >= 0; i--) begin
            btn[1] = word[i];
            @(negedge clk);
            btn[2] = 1'b1;
            repeat (4) @(negedge clk);
            btn[2] = 1'b0;
            model_word = {model_word[62:0], word[i]};
            repeat (4) @(negedge clk);
        end
    endtask

    task automatic wait_frame_end();
        int ends;
        ends = frame_end_cnt;
        while (frame_end_cnt == ends)
            @(negedge clk);
    endtask

    // Compare process picks the request up at the next frame start
    task automatic request_frame_check();
        int done;
        done = frames_checked;
        check_req_cnt++;
        while (frames_checked == done)
            @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, error_count - errors_before);
        end
    endtask

    always @(posedge oled_clk) begin : bus_decoder
        if (!oled_csn) begin
            rx_byte = {rx_byte[6:0], oled_mosi}; // MSB first
            rx_bits = rx_bits + 1;
            if (rx_bits == 8) begin
                bus_q.push_back({oled_dc, rx_byte});
                rx_bits = 0;
            end
        end
    end

    always @(posedge clk) begin : compare_bytes
        logic [8:0] entry;
        int         idx;
        int         px;
        int         py;
        while (bus_q.size() > 0) begin
            entry = bus_q.pop_front();
            if (!entry[8]) begin
                if (init_seen < init_len) begin
                    if (init_seen == 0)
                        check_value("oled_resn", oled_resn, 1);
                    check_value($sformatf("init byte %0d", init_seen), entry[7:0],
                                init_byte(init_seen));
                    init_seen++;
                end else begin
                    $display("Command byte 0x%02h sent after the init sequence at %0d ns",
                             entry[7:0], $time);
                    error_count++;
                end
            end else begin
                if (init_seen < init_len) begin
                    $display("Pixel byte sent before the init sequence ended at %0d ns", $time);
                    error_count++;
                end
                idx = pixel_seen % frame_pixels;
                px  = idx % oled_width;
                py  = idx / oled_width;
                if (idx == 0 && check_req_cnt != check_ack_cnt) begin
                    checking   = 1'b1;
                    frame_word = model_word;
                    check_ack_cnt++;
                end
                if (checking)
                    check_value($sformatf("pixel (%0d,%0d)", px, py), entry[7:0],
                                expected_color(frame_word, px, py));
                if (idx == frame_pixels - 1) begin
                    frame_end_cnt++;
                    if (checking) begin
                        checking = 1'b0;
                        frames_checked++;
                    end
                end
                pixel_seen++;
            end
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Run did not finish within %0d ns", timeout_ns);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        int          errs;
        logic [63:0] word;
        seed       = 65495;
        clk        = 1'b0;
        rst_n      = 1'b0;
        btn        = '0;
        wifi_gpio5 = 1'b0;
        model_word = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        errs = error_count;
        check_value("oled_csn", oled_csn, 1);
        check_value("oled_clk", oled_clk, 0);
        check_value("oled_dc", oled_dc, 0);
        check_value("oled_resn", oled_resn, 0);
        finish_test("reset state", errs);

        errs = error_count;
        while (init_seen < init_len)
            @(negedge clk);
        finish_test("init sequence", errs);

        errs = error_count;
        request_frame_check();
        finish_test("blank frame", errs);

        errs = error_count;
        shift_word(64'h0123456789ABCDEF);
        wait_frame_end();
        request_frame_check();
        finish_test("hex and binary", errs);

        errs = error_count;
        for (int n = 0; n < 3; n++) begin
            word = {$random(seed), $random(seed)};
            shift_word(word);
            wait_frame_end();
            request_frame_check();
        end
        finish_test("random words", errs);

        errs = error_count;
        for (int n = 0; n < 8; n++) begin
            btn[0]     = 1'($random(seed));
            wifi_gpio5 = 1'($random(seed));
            @(negedge clk);
            check_value("wifi_gpio0", wifi_gpio0, btn[0]);
            check_value("led[4]", led[4], wifi_gpio5);
            check_value("led other bits", {led[7:5], led[3:0]}, 0);
        end
        finish_test("pass-through", errs);

        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/spi_hex_pkg.sv
src/spi_slave.sv
src/hex_decoder.sv
src/oled_video.sv
src/top_spi_hex.sv
verif/spi_hex_assert.sv
verif/tb_top_spi_hex.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the SPI hex monitor testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_top_spi_hex

out=$(./obj_dir/Vtb_top_spi_hex 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi
